// File: hw/sgd_config.svh
`ifndef SGD_CONFIG_SVH
`define SGD_CONFIG_SVH

////////////////////////////////////////
// sample line geometry
////////////////////////////////////////
`define SGD_NUM_BANKS          4
`define SGD_BITS_PER_BANK      8

// model x memory, 64 words
`define SGD_X_ADDR_BITS        6
`define SGD_X_WIDTH            16

// dot, label and loss words
`define SGD_ACC_WIDTH          32

// run configuration fields
`define SGD_PLANE_BITS         4
`define SGD_CHUNK_BITS         3
`define SGD_STEP_BITS          5

// queues
`define SGD_B_FIFO_DEPTH_BITS  3
`define SGD_DOT_QUEUE_DEPTH    4

`endif

// File: hw/sgd_pkg.sv
`include "sgd_config.svh"

package sgd_pkg;

	////////////////////////////////////////
	// data types
	////////////////////////////////////////

	// one bit plane, one byte per sample bank
	// bit j of a bank byte belongs to feature chunk*8+j
	typedef logic [`SGD_NUM_BANKS-1:0][`SGD_BITS_PER_BANK-1:0] a_line_t;

	// signed word for dot, label and loss values
	typedef logic signed [`SGD_ACC_WIDTH-1:0] acc_t;

	// one value per sample bank
	typedef struct packed {
		acc_t [`SGD_NUM_BANKS-1:0] bank;
	} bank_vec_t;

	////////////////////////////////////////
	// run configuration
	////////////////////////////////////////

	// chunks of zero wraps around to eight lines per plane
	typedef struct packed {
		logic [`SGD_CHUNK_BITS-1:0] chunks;
		logic [`SGD_PLANE_BITS-1:0] num_bits;
		logic [`SGD_STEP_BITS-1:0]  step_shift;
	} sgd_cfg_t;

	// dot engine FSM
	typedef enum logic [1:0] {
		DOT_IDLE,
		DOT_ACCUM,
		DOT_EMIT
	} dot_state_e;

endpackage

// File: hw/sgd_dot_product.sv
`timescale 1ns/1ps
`include "sgd_config.svh"

module sgd_dot_product import sgd_pkg::*; (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            start,
	input  logic [`SGD_CHUNK_BITS-1:0]      cfg_chunks,
	input  logic [`SGD_PLANE_BITS-1:0]      cfg_num_bits,
	input  logic                            x_wr,
	input  logic [`SGD_X_ADDR_BITS-1:0]     x_addr,
	input  logic signed [`SGD_X_WIDTH-1:0]  x_data,
	input  logic                            a_wr,
	input  a_line_t                         a_line,
	output logic                            dot_valid,
	output bank_vec_t                       dot
);

	// model x, written before start
	logic signed [`SGD_X_WIDTH-1:0] x_mem [2**`SGD_X_ADDR_BITS];

	dot_state_e state;
	dot_state_e state_next;

	// position of the next line in the batch
	logic [`SGD_CHUNK_BITS-1:0] chunk_cnt;
	logic [`SGD_PLANE_BITS-1:0] plane_cnt;
	logic chunk_last;
	logic plane_last;
	logic line_take;

	// stage one
	bank_vec_t psum;
	bank_vec_t psum_r;
	logic      valid1;
	logic      first_r;
	logic      plane_start_r;
	logic      last_r;

	// stage two
	bank_vec_t acc;

	always_ff @(posedge clk) begin
		if (x_wr)
			x_mem[x_addr] <= x_data;
	end

	////////////////////////////////////////
	// FSM and line counters
	////////////////////////////////////////

	// lines are dropped until start
	assign line_take  = a_wr && (state != DOT_IDLE);
	// minus one wraps, so zero chunks gives eight
	assign chunk_last = (chunk_cnt == cfg_chunks - 1'b1);
	assign plane_last = (plane_cnt == cfg_num_bits - 1'b1);

	always_comb begin
		state_next = state;
		case (state)
			DOT_IDLE:  if (start) state_next = DOT_ACCUM;
			DOT_ACCUM: if (last_r) state_next = DOT_EMIT;
			// back to back one-line batches stay in emit
			DOT_EMIT:  state_next = last_r ? DOT_EMIT : DOT_ACCUM;
			default:   state_next = DOT_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= DOT_IDLE;
			chunk_cnt <= '0;
			plane_cnt <= '0;
		end else begin
			state <= state_next;
			if (start) begin
				chunk_cnt <= '0;
				plane_cnt <= '0;
			end else if (line_take) begin
				chunk_cnt <= chunk_last ? '0 : chunk_cnt + 1'b1;
				// planes advance after the last chunk of each plane
				if (chunk_last)
					plane_cnt <= plane_last ? '0 : plane_cnt + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// stage one, partial sums per bank
	////////////////////////////////////////

	// add x of every set feature bit in this chunk
	always_comb begin
		psum = '0;
		for (int k = 0; k < `SGD_NUM_BANKS; k++) begin
			for (int j = 0; j < `SGD_BITS_PER_BANK; j++) begin
				if (a_line[k][j])
					psum.bank[k] = psum.bank[k] + acc_t'(x_mem[{chunk_cnt, 3'(j)}]);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid1 <= 1'b0;
			last_r <= 1'b0;
		end else begin
			valid1 <= line_take;
			last_r <= line_take && chunk_last && plane_last;
		end
	end

	// flags travel with the partial sum
	always_ff @(posedge clk) begin
		psum_r        <= psum;
		first_r       <= (chunk_cnt == '0) && (plane_cnt == '0);
		plane_start_r <= (chunk_cnt == '0);
	end

	////////////////////////////////////////
	// stage two, bit-serial accumulate
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (valid1) begin
			for (int k = 0; k < `SGD_NUM_BANKS; k++) begin
				if (first_r)
					acc.bank[k] <= psum_r.bank[k];
				else if (plane_start_r)
					// next plane is one bit lower, scale the sum so far
					acc.bank[k] <= (acc.bank[k] <<< 1) + psum_r.bank[k];
				else
					acc.bank[k] <= acc.bank[k] + psum_r.bank[k];
			end
		end
	end

	// acc already holds the final totals while in emit
	always_ff @(posedge clk) begin
		if (reset)
			dot_valid <= 1'b0;
		else
			dot_valid <= (state == DOT_EMIT);
	end

	always_ff @(posedge clk) begin
		if (state == DOT_EMIT)
			dot <= acc;
	end

endmodule

// File: hw/sgd_b_fifo.sv
`timescale 1ns/1ps
`include "sgd_config.svh"

module sgd_b_fifo import sgd_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      b_wr,
	input  bank_vec_t b_data,
	input  logic      b_pop,
	output logic      b_avail,
	output bank_vec_t b_head,
	output logic      b_almost_full
);

	localparam int DEPTH = 2**`SGD_B_FIFO_DEPTH_BITS;

	bank_vec_t mem [DEPTH];

	logic [`SGD_B_FIFO_DEPTH_BITS-1:0] wr_ptr;
	logic [`SGD_B_FIFO_DEPTH_BITS-1:0] rd_ptr;
	logic [`SGD_B_FIFO_DEPTH_BITS:0]   count;
	logic                              do_wr;
	logic                              do_rd;

	// full buffer drops the write
	assign do_wr = b_wr && (count != DEPTH);
	assign do_rd = b_pop && (count != 0);

	////////////////////////////////////////
	// storage and pointers
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= b_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head visible with no read latency
	assign b_head        = mem[rd_ptr];
	assign b_avail       = (count != 0);
	// one slot of slack for a write already in flight
	assign b_almost_full = (count >= DEPTH - 1);

endmodule

// File: hw/sgd_serial_loss.sv
`timescale 1ns/1ps
`include "sgd_config.svh"

module sgd_serial_loss import sgd_pkg::*; (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [`SGD_STEP_BITS-1:0]  step_shift,
	input  logic                       dot_valid,
	input  bank_vec_t                  dot,
	input  logic                       b_avail,
	input  bank_vec_t                  b_head,
	output logic                       b_pop,
	output logic                       loss_valid,
	output bank_vec_t                  loss
);

	localparam int QD = `SGD_DOT_QUEUE_DEPTH;
	localparam int QW = $clog2(QD);

	// dot batches waiting for their labels
	bank_vec_t q_mem [QD];

	logic [QW-1:0] q_wr_ptr;
	logic [QW-1:0] q_rd_ptr;
	logic [QW:0]   q_count;
	logic          q_push;
	logic          q_pop;
	bank_vec_t     loss_next;

	////////////////////////////////////////
	// dot result queue
	////////////////////////////////////////

	assign q_push = dot_valid && (q_count != QD);
	// pair oldest dot with oldest label
	assign q_pop  = (q_count != 0) && b_avail;
	assign b_pop  = q_pop;

	always_ff @(posedge clk) begin
		if (q_push)
			q_mem[q_wr_ptr] <= dot;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			q_wr_ptr <= '0;
			q_rd_ptr <= '0;
			q_count  <= '0;
		end else begin
			if (q_push)
				q_wr_ptr <= q_wr_ptr + 1'b1;
			if (q_pop)
				q_rd_ptr <= q_rd_ptr + 1'b1;
			case ({q_push, q_pop})
				2'b10:   q_count <= q_count + 1'b1;
				2'b01:   q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase
		end
	end

	////////////////////////////////////////
	// subtract and shift
	////////////////////////////////////////

	// arithmetic shift keeps the sign of the error
	always_comb begin
		logic signed [`SGD_ACC_WIDTH-1:0] diff;
		loss_next = '0;
		for (int k = 0; k < `SGD_NUM_BANKS; k++) begin
			diff = q_mem[q_rd_ptr].bank[k] - b_head.bank[k];
			loss_next.bank[k] = diff >>> step_shift;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			loss_valid <= 1'b0;
		else
			loss_valid <= q_pop;
	end

	always_ff @(posedge clk) begin
		if (q_pop)
			loss <= loss_next;
	end

endmodule

// File: hw/sgd_bw_top.sv
`timescale 1ns/1ps
`include "sgd_config.svh"

module sgd_bw_top import sgd_pkg::*; (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             start,
	input  logic [`SGD_X_ADDR_BITS:0]        dimension,
	input  logic [`SGD_PLANE_BITS-1:0]       number_of_bits,
	input  logic [`SGD_STEP_BITS-1:0]        step_size,
	input  logic                             x_wr,
	input  logic [`SGD_X_ADDR_BITS-1:0]      x_addr,
	input  logic signed [`SGD_X_WIDTH-1:0]   x_data,
	input  logic                             a_wr,
	input  a_line_t                          a_line,
	input  logic                             b_wr,
	input  bank_vec_t                        b_data,
	output logic                             b_almost_full,
	output logic                             loss_valid,
	output bank_vec_t                        loss
);

	sgd_cfg_t  cfg;

	// dot engine to loss stage
	logic      dot_valid;
	bank_vec_t dot;

	// label buffer handshake
	logic      b_avail;
	bank_vec_t b_head;
	logic      b_pop;

	////////////////////////////////////////
	// run configuration
	////////////////////////////////////////

	// lines per plane is dimension/8, 64 features lands on 0 and means 8
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg <= '0;
		end else if (start) begin
			cfg.chunks     <= dimension[`SGD_X_ADDR_BITS-1:3];
			cfg.num_bits   <= number_of_bits;
			cfg.step_shift <= step_size;
		end
	end

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////

	sgd_dot_product dot_product_i (
		.clk          (clk),
		.reset        (reset),
		.start        (start),
		.cfg_chunks   (cfg.chunks),
		.cfg_num_bits (cfg.num_bits),
		.x_wr         (x_wr),
		.x_addr       (x_addr),
		.x_data       (x_data),
		.a_wr         (a_wr),
		.a_line       (a_line),
		.dot_valid    (dot_valid),
		.dot          (dot)
	);

	sgd_b_fifo b_fifo_i (
		.clk           (clk),
		.reset         (reset),
		.b_wr          (b_wr),
		.b_data        (b_data),
		.b_pop         (b_pop),
		.b_avail       (b_avail),
		.b_head        (b_head),
		.b_almost_full (b_almost_full)
	);

	sgd_serial_loss serial_loss_i (
		.clk        (clk),
		.reset      (reset),
		.step_shift (cfg.step_shift),
		.dot_valid  (dot_valid),
		.dot        (dot),
		.b_avail    (b_avail),
		.b_head     (b_head),
		.b_pop      (b_pop),
		.loss_valid (loss_valid),
		.loss       (loss)
	);

endmodule

// File: tests/sgd_bw_top_chk.sv
`timescale 1ns/1ps

module sgd_bw_top_chk (
	input logic clk,
	input logic reset,
	input logic dot_valid,
	input logic loss_valid,
	input logic b_pop,
	input logic b_avail,
	input logic b_almost_full
);

	// dot batches seen that have not yet turned into a loss
	int dots_open;

	always_ff @(posedge clk) begin
		if (reset)
			dots_open <= 0;
		else
			dots_open <= dots_open + int'(dot_valid) - int'(loss_valid);
	end

	////////////////////////////////////////
	// loss stage protocol
	////////////////////////////////////////

	// every loss pulse comes from a pop one cycle earlier
	// and pairs with a dot batch of its own
	a_loss_after_pop: assert property (@(posedge clk) disable iff (reset)
		loss_valid |-> ($past(b_pop) && (dots_open != 0)))
		else $error("loss_valid without a pop or without a pending dot batch");

	// never pop an empty label buffer
	a_pop_needs_label: assert property (@(posedge clk) disable iff (reset)
		b_pop |-> b_avail)
		else $error("b_pop while b_avail is low");

	// quiet outputs right after reset
	a_reset_outputs: assert property (@(posedge clk)
		($past(reset) && !reset) |-> (!loss_valid && !b_almost_full))
		else $error("loss_valid or b_almost_full high after reset");

endmodule

bind sgd_bw_top sgd_bw_top_chk chk_i (.*);

// File: tests/sgd_bw_top_tb.sv
`timescale 1ns/1ps
`include "sgd_config.svh"

module sgd_bw_top_tb import sgd_pkg::*; ();

	logic                            clk;
	logic                            reset;
	logic                            start;
	logic [`SGD_X_ADDR_BITS:0]       dimension;
	logic [`SGD_PLANE_BITS-1:0]      number_of_bits;
	logic [`SGD_STEP_BITS-1:0]       step_size;
	logic                            x_wr;
	logic [`SGD_X_ADDR_BITS-1:0]     x_addr;
	logic signed [`SGD_X_WIDTH-1:0]  x_data;
	logic                            a_wr;
	a_line_t                         a_line;
	logic                            b_wr;
	bank_vec_t                       b_data;
	logic                            b_almost_full;
	logic                            loss_valid;
	bank_vec_t                       loss;

	// expected and observed loss batches, oldest first
	bank_vec_t exp_q[$];
	bank_vec_t got_q[$];
	int        cycles = 0;
	int        limit = 0;
	int        test_errs = 0;
	int        pass_count = 0;
	int        fail_count = 0;
	string     name = "reset";

	sgd_bw_top sgd_bw_top_i (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// loss_valid is a one-cycle pulse, seen at exactly one falling edge
	always @(negedge clk) begin
		if (loss_valid)
			got_q.push_back(loss);
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("timeout after %0d cycles in test %s, losses missing or run stuck", cycles, name);
			$display("Result: FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic next_cycle();
		@(negedge clk);
	endtask

	function automatic bit is_record_tag(string t);
		return t == "test" || t == "x" || t == "cfg" || t == "a" || t == "b" || t == "e"
			|| t == "af" || t == "sync" || t == "end";
	endfunction

	// wait for every expected batch, then compare bank by bank
	task automatic wait_losses();
		bank_vec_t e;
		bank_vec_t g;
		while (got_q.size() < exp_q.size())
			next_cycle();
		while (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			g = got_q.pop_front();
			for (int k = 0; k < `SGD_NUM_BANKS; k++) begin
				if (g.bank[k] !== e.bank[k]) begin
					$display("CHECK FAILED at %0t: %s bank %0d expected %0d got %0d",
						$time, name, k, e.bank[k], g.bank[k]);
					test_errs++;
				end
			end
		end
	endtask

	task automatic finish_test();
		// a loss nobody asked for shows up here
		repeat (10) next_cycle();
		if (got_q.size() != 0) begin
			$display("test %s: %0d unexpected loss results", name, got_q.size());
			test_errs++;
			got_q.delete();
		end
		if (test_errs == 0)
			pass_count++;
		else
			fail_count++;
		$display("test %s finished with %0d errors", name, test_errs);
		test_errs = 0;
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		int        fd;
		int        r;
		int        records;
		int        v[4];
		int        gaps;
		logic [31:0] aval;
		string     tag;
		string     rest;
		bank_vec_t bv;
		void'($urandom(87));
		{start, dimension, number_of_bits, step_size} = '0;
		{x_wr, x_addr, x_data, a_wr, a_line, b_wr, b_data} = '0;
		gaps = 0;
		reset = 1'b1;
		repeat (10) next_cycle();
		reset = 1'b0;
		next_cycle();
		// outputs quiet after reset, nothing sent yet
		if (loss_valid !== 1'b0 || b_almost_full !== 1'b0) begin
			$display("CHECK FAILED at %0t: reset outputs not low", $time);
			test_errs++;
		end
		finish_test();
		// first pass only counts records for the timeout
		records = 0;
		fd = $fopen("tests/sgd_bw_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/sgd_bw_stimulus.txt");
			$display("Result: FAILED");
			$finish;
		end
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag[0] == "#")
				r = $fgets(rest, fd);
			else if (is_record_tag(tag))
				records++;
		end
		$fclose(fd);
		limit = cycles + records * 20 + 200;
		fd = $fopen("tests/sgd_bw_stimulus.txt", "r");
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag[0] == "#") begin
				r = $fgets(rest, fd);
			end else if (tag == "test") begin
				r = $fscanf(fd, "%s", name);
			end else if (tag == "x") begin
				r = $fscanf(fd, "%d %d", v[0], v[1]);
				x_wr = 1'b1;
				x_addr = v[0];
				x_data = v[1];
				next_cycle();
				x_wr = 1'b0;
			end else if (tag == "cfg") begin
				r = $fscanf(fd, "%d %d %d %d", v[0], v[1], v[2], gaps);
				start = 1'b1;
				dimension = v[0];
				number_of_bits = v[1];
				step_size = v[2];
				next_cycle();
				start = 1'b0;
			end else if (tag == "a") begin
				r = $fscanf(fd, "%h", aval);
				a_wr = 1'b1;
				a_line = aval;
				next_cycle();
				a_wr = 1'b0;
				// random idle gap of 0 to 2 cycles
				if (gaps != 0)
					repeat ($urandom % 3) next_cycle();
			end else if (tag == "b" || tag == "e") begin
				r = $fscanf(fd, "%d %d %d %d", v[0], v[1], v[2], v[3]);
				for (int k = 0; k < `SGD_NUM_BANKS; k++)
					bv.bank[k] = v[k];
				if (tag == "e") begin
					exp_q.push_back(bv);
				end else begin
					b_wr = 1'b1;
					b_data = bv;
					next_cycle();
					b_wr = 1'b0;
				end
			end else if (tag == "af") begin
				r = $fscanf(fd, "%d", v[0]);
				if (b_almost_full !== v[0][0]) begin
					$display("CHECK FAILED at %0t: %s b_almost_full expected %0d got %b",
						$time, name, v[0], b_almost_full);
					test_errs++;
				end
			end else if (tag == "sync") begin
				wait_losses();
			end else if (tag == "end") begin
				wait_losses();
				finish_test();
			end else begin
				$display("unknown record %s in stimulus file", tag);
				fail_count++;
			end
		end
		$fclose(fd);
		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: tests/sgd_bw_stimulus.txt
# records: test name | x addr value | cfg dimension planes step gaps | a line hex bank3..bank0
# b labels and e expected losses, four signed values bank0..bank3 | af level | sync | end
test single
x 0 1 x 1 2 x 2 3 x 3 4 x 4 5 x 5 6 x 6 7 x 7 8
x 8 9 x 9 10 x 10 11 x 11 12 x 12 13 x 13 14 x 14 15 x 15 16
cfg 16 4 0 1
b 100 10 -6 29
a 00000100 a 00000000 a 00000000 a 00800000
a 0f000000 a 00000000 a 000000ff a 010000ff
e 36 -2 70 0
end
test shift
x 0 -100 x 1 -3 x 2 50 x 3 7
cfg 8 2 3 1
b 0 3 -1 50
a 00030401 a f0080002
e -26 12 -25 -3
end
test late_labels
cfg 8 2 1 1
a 00000010 a ff000100 a 00800000 a 00800004
b 0 0 0 0 b 1 1 1 1
e 5 -50 0 -10 e 24 -1 11 -1
end
test overlap
cfg 8 2 0 0
b 0 0 0 0 b 0 0 0 0 b 1 2 3 4
a 000000ff a 00000000 a 00000000 a 01010101 a 00002000 a 08000000
e -40 0 0 0 e -100 -100 -100 -100 e -1 10 -3 3
end
test backpressure
cfg 8 2 2 1
b 4 0 0 0 b 0 8 0 0 b 0 0 0 -6 b 0 0 0 0 b 0 0 0 0 b 0 0 0 0 b 0 0 0 0
af 1
a 00000001 a 00000000 a 00000000 a 00000400 a 10000000 a 00080000
e -51 0 0 0 e 0 10 0 0 e 0 0 1 4
sync
af 0
end

// File: sgd_bw_top.f
+incdir+hw
hw/sgd_pkg.sv
hw/sgd_dot_product.sv
hw/sgd_b_fifo.sv
hw/sgd_serial_loss.sv
hw/sgd_bw_top.sv
tests/sgd_bw_top_chk.sv
tests/sgd_bw_top_tb.sv

// File: Bender.yml
package:
  name: sgd_bw

sources:
  - include_dirs:
      - hw
    files:
      - hw/sgd_pkg.sv
      - hw/sgd_dot_product.sv
      - hw/sgd_b_fifo.sv
      - hw/sgd_serial_loss.sv
      - hw/sgd_bw_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tests/sgd_bw_top_chk.sv
      - tests/sgd_bw_top_tb.sv
